/* verilog/rvPkg.sv */
package rvPkg;

	localparam int xlen = 32;
	localparam int pcW = 12; // Byte address into instruction memory
	localparam int dAddrW = 12; // Word address into data memory
	localparam int regAddrW = 5;

	localparam logic [6:0] opOp = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;

	localparam logic [xlen-1:0] haltInstr = 32'h00008067; // jalr x0, 0(x1)

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} aluOpT;

	typedef enum logic [1:0] {memByte, memHalf, memWord} memSizeT; // Same code as funct3[1:0]

	typedef enum logic [1:0] {fwdRf, fwdMem, fwdWb} fwdSelT;

	typedef enum logic [1:0] {brEq, brLt, brLtu} brCondT; // funct3[0] inverts

	typedef struct packed {
		aluOpT aluOp;
		logic useImm;
		logic isLoad;
		logic isStore;
		logic isBranch;
		logic isJal;
		logic isJalr;
		logic regWrite; // Already zero for rd == x0
		memSizeT memSize;
		logic loadUnsigned;
		brCondT branchCond;
		logic [2:0] funct3;
	} ctrlT;

	typedef struct packed {
		logic [pcW-1:0] pc;
		logic [xlen-1:0] instr;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		logic [pcW-1:0] pc;
		logic [regAddrW-1:0] rs1;
		logic [regAddrW-1:0] rs2;
		logic [regAddrW-1:0] rd;
		logic [xlen-1:0] opA;
		logic [xlen-1:0] opB;
		logic [xlen-1:0] imm;
		logic [xlen-1:0] instr;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		logic [regAddrW-1:0] rd;
		logic [xlen-1:0] result;
		logic [xlen-1:0] storeData;
		logic [xlen-1:0] instr; // For halt detection
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic [regAddrW-1:0] rd;
		logic [xlen-1:0] value;
		logic halt;
	} memWbT;

endpackage

/* verilog/stageReg.sv */
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic
) (
	input logic CLK,
	input logic RSTn,
	input logic stall,
	input logic flush,
	input logic inValid,
	input payloadT inData,
	output logic outValid,
	output payloadT outData
);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			outValid <= 1'b0;
		end else if (flush) begin
			outValid <= 1'b0; // Flush beats stall
		end else if (!stall) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall) begin
			outData <= inData;
		end
	end

	assert property (@(posedge CLK) RSTn |=> !outValid)
		else $error("stage valid set right after reset");

endmodule

/* verilog/decoder.sv */
`timescale 1ns/1ps

module decoder
	import rvPkg::*;
(
	input logic [xlen-1:0] instr,
	output ctrlT ctrl,
	output logic [regAddrW-1:0] rs1,
	output logic [regAddrW-1:0] rs2,
	output logic [regAddrW-1:0] rd,
	output logic [xlen-1:0] imm
);

	logic [2:0] funct3;
	logic alt;
	logic [xlen-1:0] immI;
	logic [xlen-1:0] immS;
	logic [xlen-1:0] immB;
	logic [xlen-1:0] immJ;

	function automatic aluOpT aluFor(input logic [2:0] f3, input logic subSel, input logic sraSel);
		case (f3)
			3'b000: return subSel ? aluSub : aluAdd;
			3'b001: return aluSll;
			3'b010: return aluSlt;
			3'b011: return aluSltu;
			3'b100: return aluXor;
			3'b101: return sraSel ? aluSra : aluSrl;
			3'b110: return aluOr;
			default: return aluAnd;
		endcase
	endfunction

	assign funct3 = instr[14:12];
	assign alt = instr[30];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	assign immI = {{(xlen-12){instr[31]}}, instr[31:20]};
	assign immS = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{(xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{(xlen-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		ctrl = '0; // Unknown opcodes fall through as a no-op
		imm = immI;
		ctrl.funct3 = funct3;
		case (instr[6:0])
			opOp: begin
				ctrl.aluOp = aluFor(funct3, alt, alt);
				ctrl.regWrite = 1'b1;
			end
			opImm: begin
				ctrl.aluOp = aluFor(funct3, 1'b0, alt);
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			opLoad: begin
				ctrl.useImm = 1'b1;
				ctrl.isLoad = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memSize = memSizeT'(funct3[1:0]);
				ctrl.loadUnsigned = funct3[2];
			end
			opStore: begin
				ctrl.useImm = 1'b1;
				ctrl.isStore = 1'b1;
				ctrl.memSize = memSizeT'(funct3[1:0]);
				imm = immS;
			end
			opBranch: begin
				ctrl.isBranch = 1'b1;
				ctrl.branchCond = funct3[2] ? (funct3[1] ? brLtu : brLt) : brEq;
				imm = immB;
			end
			opJal: begin
				ctrl.aluOp = aluPassB; // Link value
				ctrl.isJal = 1'b1;
				ctrl.regWrite = 1'b1;
				imm = immJ;
			end
			opJalr: begin
				ctrl.aluOp = aluPassB;
				ctrl.useImm = 1'b1;
				ctrl.isJalr = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			default: ;
		endcase
		if (rd == '0) begin
			ctrl.regWrite = 1'b0;
		end
	end

endmodule

/* verilog/execUnit.sv */
`timescale 1ns/1ps

module execUnit
	import rvPkg::*;
(
	input ctrlT ctrl,
	input logic [pcW-1:0] pc,
	input logic [xlen-1:0] opA,
	input logic [xlen-1:0] opB,
	input logic [xlen-1:0] imm,
	output logic [xlen-1:0] result,
	output logic [xlen-1:0] storeData,
	output logic redirect,
	output logic [pcW-1:0] target
);

	logic [xlen-1:0] linkAddr;
	logic [xlen-1:0] aluB;
	logic [4:0] shamt;
	logic [pcW-1:0] jumpSum;
	logic condMet;
	logic isJump;

	assign isJump = ctrl.isJal | ctrl.isJalr;
	assign linkAddr = {{(xlen-pcW){1'b0}}, pc} + 32'd4;
	assign aluB = isJump ? linkAddr : (ctrl.useImm ? imm : opB);
	assign shamt = aluB[4:0];
	assign storeData = opB;

	always_comb begin
		case (ctrl.aluOp)
			aluAdd: result = opA + aluB;
			aluSub: result = opA - aluB;
			aluSll: result = opA << shamt;
			aluSlt: result = {{(xlen-1){1'b0}}, $signed(opA) < $signed(aluB)};
			aluSltu: result = {{(xlen-1){1'b0}}, opA < aluB};
			aluXor: result = opA ^ aluB;
			aluSrl: result = opA >> shamt;
			aluSra: result = $unsigned($signed(opA) >>> shamt);
			aluOr: result = opA | aluB;
			aluAnd: result = opA & aluB;
			aluPassB: result = aluB;
			default: result = '0;
		endcase
	end

	// Branch compare always uses the register operands
	always_comb begin
		case (ctrl.branchCond)
			brLt: condMet = $signed(opA) < $signed(opB);
			brLtu: condMet = opA < opB;
			default: condMet = opA == opB;
		endcase
	end

	assign redirect = isJump | (ctrl.isBranch & (condMet ^ ctrl.funct3[0]));

	always_comb begin
		if (ctrl.isJalr) begin
			jumpSum = pcW'(opA + imm);
		end else begin
			jumpSum = pc + pcW'(imm); // Branch and JAL
		end
	end

	assign target = {jumpSum[pcW-1:1], 1'b0};

endmodule

/* verilog/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit
	import rvPkg::*;
(
	input logic [regAddrW-1:0] idRs1,
	input logic [regAddrW-1:0] idRs2,
	input logic [regAddrW-1:0] exRs1,
	input logic [regAddrW-1:0] exRs2,
	input logic [regAddrW-1:0] exRd,
	input logic exIsLoad,
	input logic exValid,
	input logic [regAddrW-1:0] memRd,
	input logic memRegWrite,
	input logic memValid,
	input logic [regAddrW-1:0] wbRd,
	input logic wbRegWrite,
	input logic wbValid,
	input logic redirect,
	output fwdSelT fwdA,
	output fwdSelT fwdB,
	output logic idBypassA,
	output logic idBypassB,
	output logic stall,
	output logic flushIdEx,
	output logic flushIfId
);

	logic memLive;
	logic wbLive;

	function automatic fwdSelT selectSrc(
		input logic [regAddrW-1:0] rs,
		input logic [regAddrW-1:0] mRd,
		input logic mLive,
		input logic [regAddrW-1:0] wRd,
		input logic wLive
	);
		if (mLive && mRd == rs) begin
			return fwdMem; // Youngest producer first
		end
		if (wLive && wRd == rs) begin
			return fwdWb;
		end
		return fwdRf;
	endfunction

	assign memLive = memValid & memRegWrite;
	assign wbLive = wbValid & wbRegWrite;

	assign fwdA = selectSrc(exRs1, memRd, memLive, wbRd, wbLive);
	assign fwdB = selectSrc(exRs2, memRd, memLive, wbRd, wbLive);

	// RF returns the old value during a same-cycle write
	assign idBypassA = wbLive & (wbRd == idRs1);
	assign idBypassB = wbLive & (wbRd == idRs2);

	assign stall = exValid & exIsLoad & (exRd != '0) & ((exRd == idRs1) | (exRd == idRs2));
	assign flushIfId = redirect;
	assign flushIdEx = redirect | stall; // Bubble into EX on load-use

	always_comb begin
		assert (!(stall && redirect && exValid))
			else $error("load-use stall and redirect from one EX instruction");
	end

endmodule

/* verilog/memAccess.sv */
`timescale 1ns/1ps

module memAccess
	import rvPkg::*;
(
	input ctrlT ctrl,
	input logic valid,
	input logic [1:0] byteAddr,
	input logic [xlen-1:0] storeData,
	input logic [xlen-1:0] loadWord,
	output logic wen,
	output logic [3:0] byteEn,
	output logic [xlen-1:0] laneData,
	output logic [xlen-1:0] loadValue
);

	logic [xlen-1:0] shifted;

	assign wen = ~(valid & ctrl.isStore); // Active low
	assign laneData = storeData << {byteAddr, 3'b000};
	assign shifted = loadWord >> {byteAddr, 3'b000};

	always_comb begin
		case (ctrl.memSize)
			memByte: byteEn = 4'b0001 << byteAddr;
			memHalf: byteEn = 4'b0011 << byteAddr;
			default: byteEn = 4'b1111;
		endcase
	end

	always_comb begin
		case (ctrl.memSize)
			memByte: loadValue = {{(xlen-8){~ctrl.loadUnsigned & shifted[7]}}, shifted[7:0]};
			memHalf: loadValue = {{(xlen-16){~ctrl.loadUnsigned & shifted[15]}}, shifted[15:0]};
			default: loadValue = loadWord;
		endcase
	end

	always_comb begin
		if (valid && (ctrl.isLoad || ctrl.isStore) && ctrl.memSize != memByte) begin
			assert ((ctrl.memSize == memHalf) ? !byteAddr[0] : (byteAddr == 2'b00))
				else $error("misaligned data access");
		end
	end

endmodule

/* verilog/rvCore.sv */
`timescale 1ns/1ps

module rvCore
	import rvPkg::*;
(
	input logic CLK,
	input logic RSTn,
	output logic I_MEM_CSN,
	output logic [pcW-1:0] I_MEM_ADDR,
	input logic [xlen-1:0] I_MEM_DI,
	output logic D_MEM_CSN,
	output logic [xlen-1:0] D_MEM_DOUT,
	output logic [dAddrW-1:0] D_MEM_ADDR,
	output logic D_MEM_WEN,
	output logic [3:0] D_MEM_BE,
	input logic [xlen-1:0] D_MEM_DI,
	output logic RF_WE,
	output logic [regAddrW-1:0] RF_RA1,
	output logic [regAddrW-1:0] RF_RA2,
	output logic [regAddrW-1:0] RF_WA1,
	output logic [xlen-1:0] RF_WD,
	input logic [xlen-1:0] RF_RD1,
	input logic [xlen-1:0] RF_RD2,
	output logic HALT,
	output logic [31:0] NUM_INST,
	output logic [xlen-1:0] OUTPUT_PORT
);

	logic [pcW-1:0] pc;
	ifIdT ifIdIn;
	ifIdT ifIdOut;
	idExT idExIn;
	idExT idExOut;
	exMemT exMemIn;
	exMemT exMemOut;
	memWbT memWbIn;
	memWbT memWbOut;
	logic ifIdValid;
	logic idExValid;
	logic exMemValid;
	logic memWbValid;
	ctrlT idCtrl;
	logic [regAddrW-1:0] idRd;
	logic [xlen-1:0] idImm;
	fwdSelT fwdA;
	fwdSelT fwdB;
	logic idBypassA;
	logic idBypassB;
	logic stall;
	logic flushIdEx;
	logic flushIfId;
	logic exTaken;
	logic redirect;
	logic [pcW-1:0] target;
	logic [xlen-1:0] exOpA;
	logic [xlen-1:0] exOpB;
	logic [xlen-1:0] exResult;
	logic [xlen-1:0] exStoreData;
	logic [xlen-1:0] loadValue;
	logic haltSeen;

	function automatic logic [xlen-1:0] fwdValue(input fwdSelT sel, input logic [xlen-1:0] own,
		input logic [xlen-1:0] memVal, input logic [xlen-1:0] wbVal);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return own;
		endcase
	endfunction

	// Halt on its way down the pipe or already taken
	assign haltSeen = HALT | (memWbValid & memWbOut.halt)
		| (exMemValid & (exMemOut.instr == haltInstr));
	assign redirect = exTaken & idExValid;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= target;
		end else if (!stall && !haltSeen) begin
			pc <= pc + pcW'(4);
		end
	end

	assign I_MEM_CSN = RSTn;
	assign I_MEM_ADDR = pc;
	assign ifIdIn = '{pc: pc, instr: I_MEM_DI};

	stageReg #(.payloadT(ifIdT)) ifId (.CLK(CLK), .RSTn(RSTn), .stall(stall), .flush(flushIfId),
		.inValid(!haltSeen), .inData(ifIdIn), .outValid(ifIdValid), .outData(ifIdOut));

	decoder u_decoder (.instr(ifIdOut.instr), .ctrl(idCtrl), .rs1(RF_RA1), .rs2(RF_RA2),
		.rd(idRd), .imm(idImm));

	assign idExIn = '{ctrl: idCtrl, pc: ifIdOut.pc, rs1: RF_RA1, rs2: RF_RA2, rd: idRd,
		opA: idBypassA ? RF_WD : RF_RD1, opB: idBypassB ? RF_WD : RF_RD2,
		imm: idImm, instr: ifIdOut.instr};

	stageReg #(.payloadT(idExT)) idEx (.CLK(CLK), .RSTn(RSTn), .stall(1'b0), .flush(flushIdEx),
		.inValid(ifIdValid), .inData(idExIn), .outValid(idExValid), .outData(idExOut));

	hazardUnit u_hazardUnit (.idRs1(RF_RA1), .idRs2(RF_RA2),
		.exRs1(idExOut.rs1), .exRs2(idExOut.rs2), .exRd(idExOut.rd),
		.exIsLoad(idExOut.ctrl.isLoad), .exValid(idExValid),
		.memRd(exMemOut.rd), .memRegWrite(exMemOut.ctrl.regWrite), .memValid(exMemValid),
		.wbRd(memWbOut.rd), .wbRegWrite(memWbOut.regWrite), .wbValid(memWbValid),
		.redirect(redirect), .fwdA(fwdA), .fwdB(fwdB), .idBypassA(idBypassA),
		.idBypassB(idBypassB), .stall(stall), .flushIdEx(flushIdEx), .flushIfId(flushIfId));

	assign exOpA = fwdValue(fwdA, idExOut.opA, exMemOut.result, memWbOut.value);
	assign exOpB = fwdValue(fwdB, idExOut.opB, exMemOut.result, memWbOut.value);

	execUnit u_execUnit (.ctrl(idExOut.ctrl), .pc(idExOut.pc), .opA(exOpA), .opB(exOpB),
		.imm(idExOut.imm), .result(exResult), .storeData(exStoreData),
		.redirect(exTaken), .target(target));

	assign exMemIn = '{ctrl: idExOut.ctrl, rd: idExOut.rd, result: exResult,
		storeData: exStoreData, instr: idExOut.instr};

	stageReg #(.payloadT(exMemT)) exMem (.CLK(CLK), .RSTn(RSTn), .stall(1'b0), .flush(1'b0),
		.inValid(idExValid), .inData(exMemIn), .outValid(exMemValid), .outData(exMemOut));

	assign D_MEM_CSN = RSTn;
	assign D_MEM_ADDR = exMemOut.result[dAddrW+1:2];

	memAccess u_memAccess (.ctrl(exMemOut.ctrl), .valid(exMemValid),
		.byteAddr(exMemOut.result[1:0]), .storeData(exMemOut.storeData), .loadWord(D_MEM_DI),
		.wen(D_MEM_WEN), .byteEn(D_MEM_BE), .laneData(D_MEM_DOUT), .loadValue(loadValue));

	assign memWbIn = '{regWrite: exMemOut.ctrl.regWrite, rd: exMemOut.rd,
		value: exMemOut.ctrl.isLoad ? loadValue : exMemOut.result,
		halt: exMemOut.instr == haltInstr};

	stageReg #(.payloadT(memWbT)) memWb (.CLK(CLK), .RSTn(RSTn), .stall(1'b0), .flush(1'b0),
		.inValid(exMemValid), .inData(memWbIn), .outValid(memWbValid), .outData(memWbOut));

	assign RF_WE = memWbValid & memWbOut.regWrite;
	assign RF_WA1 = memWbOut.rd;
	assign RF_WD = memWbOut.value;
	assign OUTPUT_PORT = RF_WD;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			NUM_INST <= '0;
			HALT <= 1'b0;
		end else begin
			if (memWbValid) begin
				NUM_INST <= NUM_INST + 32'd1;
			end
			if (memWbValid && memWbOut.halt) begin
				HALT <= 1'b1; // Sticky
			end
		end
	end

	assert property (@(posedge CLK) disable iff (RSTn) !(RF_WE && RF_WA1 == '0))
		else $error("register write to x0");

endmodule

/* testbench/programTable.svh */
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

typedef struct packed {
	logic [4:0] rd;
	logic [31:0] value;
} expWriteT;

localparam int otherCount = 10; // 3 stores, 6 branches, halt

expWriteT expTable[$];
logic [31:0] expWord66;
logic [31:0] expWord67;

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, opOp};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
endfunction

function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

task automatic addExp(input logic [4:0] rd, input logic [31:0] value);
	expTable.push_back(expWriteT'{rd: rd, value: value});
endtask

task automatic loadProgram(input logic [31:0] w0, input logic [31:0] w1, input logic [31:0] w2);
	logic [31:0] x12;
	logic [31:0] x13;
	logic [31:0] x14;
	for (int i = 0; i < 1024; i++) begin
		imem[i] = encI(12'(i), 5'd0, 3'd0, 5'd0, opImm); // nop
	end
	imem[0] = encI(12'd5, 5'd0, 3'd0, 5'd1, opImm);
	imem[1] = encI(12'd3, 5'd1, 3'd0, 5'd2, opImm); // MEM forward
	imem[2] = encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
	imem[3] = encR(7'h20, 5'd1, 5'd3, 3'd0, 5'd4); // x1 through ID bypass
	imem[4] = encR(7'h00, 5'd1, 5'd4, 3'd6, 5'd5);
	imem[5] = encI(12'h100, 5'd0, 3'd0, 5'd10, opImm);
	imem[6] = encI(12'd0, 5'd10, 3'd2, 5'd11, opLoad);
	imem[7] = encR(7'h00, 5'd1, 5'd11, 3'd0, 5'd12); // Load-use
	imem[8] = encI(12'd1, 5'd10, 3'd0, 5'd13, opLoad);
	imem[9] = encI(12'd2, 5'd10, 3'd5, 5'd14, opLoad);
	imem[10] = encI(12'd6, 5'd10, 3'd1, 5'd15, opLoad);
	imem[11] = encI(12'd4, 5'd10, 3'd4, 5'd16, opLoad);
	imem[12] = encS(12'd8, 5'd12, 5'd10, 3'd0);
	imem[13] = encS(12'd10, 5'd13, 5'd10, 3'd1);
	imem[14] = encS(12'd12, 5'd14, 5'd10, 3'd2);
	imem[15] = encI(12'd8, 5'd10, 3'd2, 5'd17, opLoad);
	imem[16] = encR(7'h00, 5'd0, 5'd13, 3'd2, 5'd18);
	imem[17] = encB(13'd8, 5'd5, 5'd1, 3'd0); // beq, not taken
	imem[18] = encI(12'd1, 5'd0, 3'd0, 5'd19, opImm);
	imem[19] = encB(13'd8, 5'd5, 5'd1, 3'd1); // bne, taken
	imem[20] = encI(12'd99, 5'd0, 3'd0, 5'd19, opImm);
	imem[21] = encB(13'd8, 5'd1, 5'd4, 3'd4); // blt, not taken
	imem[22] = encB(13'd8, 5'd4, 5'd1, 3'd6); // bltu, taken
	imem[23] = encI(12'd77, 5'd0, 3'd0, 5'd20, opImm);
	imem[24] = encB(13'd8, 5'd1, 5'd4, 3'd5); // bge, taken
	imem[25] = encI(12'd66, 5'd0, 3'd0, 5'd20, opImm);
	imem[26] = encB(13'd8, 5'd4, 5'd1, 3'd7); // bgeu, not taken
	imem[27] = encJ(21'd8, 5'd21);
	imem[28] = encI(12'd55, 5'd0, 3'd0, 5'd22, opImm);
	imem[29] = encI(12'd140, 5'd0, 3'd0, 5'd23, opImm);
	imem[30] = encI(12'd0, 5'd23, 3'd0, 5'd24, opJalr);
	for (int i = 31; i < 35; i++) begin
		imem[i] = encI(12'd11, 5'd0, 3'd0, 5'd25, opImm); // Skipped by jalr
	end
	imem[35] = encR(7'h00, 5'd24, 5'd21, 3'd0, 5'd26);
	imem[36] = haltInstr;
	imem[37] = encI(12'd1, 5'd0, 3'd0, 5'd27, opImm);
	imem[38] = encI(12'd2, 5'd0, 3'd0, 5'd27, opImm);

	x12 = w0 + 32'd5;
	x13 = {{24{w0[15]}}, w0[15:8]};
	x14 = {16'h0000, w0[31:16]};
	addExp(5'd1, 32'd5);
	addExp(5'd2, 32'd8);
	addExp(5'd3, 32'd13);
	addExp(5'd4, 32'd8);
	addExp(5'd5, 32'd13);
	addExp(5'd10, 32'h100);
	addExp(5'd11, w0);
	addExp(5'd12, x12);
	addExp(5'd13, x13);
	addExp(5'd14, x14);
	addExp(5'd15, {{16{w1[31]}}, w1[31:16]});
	addExp(5'd16, {24'h000000, w1[7:0]});
	expWord66 = {x13[15:0], w2[15:8], x12[7:0]};
	expWord67 = x14;
	addExp(5'd17, expWord66);
	addExp(5'd18, {31'h0, x13[31]});
	addExp(5'd19, 32'd1);
	addExp(5'd21, 32'd112); // Link of jal at 108
	addExp(5'd23, 32'd140);
	addExp(5'd24, 32'd124);
	addExp(5'd26, 32'd236);
endtask

`endif

/* testbench/tbCore.sv */
`timescale 1ns/1ps

module tbCore
	import rvPkg::*;
;

	logic CLK;
	logic RSTn;
	logic I_MEM_CSN;
	logic [pcW-1:0] I_MEM_ADDR;
	logic [xlen-1:0] I_MEM_DI;
	logic D_MEM_CSN;
	logic [xlen-1:0] D_MEM_DOUT;
	logic [dAddrW-1:0] D_MEM_ADDR;
	logic D_MEM_WEN;
	logic [3:0] D_MEM_BE;
	logic [xlen-1:0] D_MEM_DI;
	logic RF_WE;
	logic [regAddrW-1:0] RF_RA1;
	logic [regAddrW-1:0] RF_RA2;
	logic [regAddrW-1:0] RF_WA1;
	logic [xlen-1:0] RF_WD;
	logic [xlen-1:0] RF_RD1;
	logic [xlen-1:0] RF_RD2;
	logic HALT;
	logic [31:0] NUM_INST;
	logic [xlen-1:0] OUTPUT_PORT;

	logic [31:0] imem [0:1023];
	logic [31:0] dmem [0:4095];
	logic [31:0] regs [0:31];
	integer seed;
	int cycles;
	int limit;
	int idx;

	`include "programTable.svh"

	rvCore i_rvCore (.*);

	initial begin
		CLK = 1'b0;
	end

	always #50 CLK = ~CLK;

	assign I_MEM_DI = imem[I_MEM_ADDR[pcW-1:2]];
	assign D_MEM_DI = dmem[D_MEM_ADDR];
	assign RF_RD1 = (RF_RA1 == '0) ? '0 : regs[RF_RA1];
	assign RF_RD2 = (RF_RA2 == '0) ? '0 : regs[RF_RA2];

	always @(posedge CLK) begin
		if (RF_WE && RF_WA1 != '0) begin
			regs[RF_WA1] <= RF_WD;
		end
		if (!D_MEM_CSN && !D_MEM_WEN) begin
			for (int b = 0; b < 4; b++) begin
				if (D_MEM_BE[b]) begin
					dmem[D_MEM_ADDR][b*8 +: 8] <= D_MEM_DOUT[b*8 +: 8];
				end
			end
		end
	end

	task automatic failWith(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	// Run limit grows with the expected-write table
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			failWith("Timeout waiting for the halt instruction to complete");
		end
	end

	initial begin
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		expWriteT e;
		seed = 32'h679ffe4c;
		cycles = 0;
		idx = 0;
		RSTn = 1'b1;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 4096; i++) begin
			dmem[i] = {8'hD0, i[11:0], ~i[11:0]};
		end
		w0 = $random(seed);
		w1 = $random(seed);
		w2 = $random(seed);
		dmem[64] = w0; // Byte address 0x100
		dmem[65] = w1;
		dmem[66] = w2;
		loadProgram(w0, w1, w2);
		limit = 20 * expTable.size() + 16;

		repeat (16) @(posedge CLK);
		RSTn <= 1'b0;
		@(negedge CLK);
		assert (RF_WE == 1'b0) else failWith($sformatf("Fail RF_WE got %h expected 0", RF_WE));
		assert (D_MEM_WEN == 1'b1)
			else failWith($sformatf("Fail D_MEM_WEN got %h expected 1", D_MEM_WEN));
		assert (HALT == 1'b0) else failWith($sformatf("Fail HALT got %h expected 0", HALT));
		assert (NUM_INST == 32'd0)
			else failWith($sformatf("Fail NUM_INST got %h expected 0", NUM_INST));
		assert (I_MEM_CSN == 1'b0)
			else failWith($sformatf("Fail I_MEM_CSN got %h expected 0", I_MEM_CSN));
		assert (D_MEM_CSN == 1'b0)
			else failWith($sformatf("Fail D_MEM_CSN got %h expected 0", D_MEM_CSN));

		while (!HALT) begin
			if (RF_WE) begin
				assert (idx < expTable.size())
					else failWith("More register writes than expected");
				e = expTable[idx];
				assert (RF_WA1 == e.rd)
					else failWith($sformatf("Fail RF_WA1 got %h expected %h", RF_WA1, e.rd));
				assert (RF_WD == e.value)
					else failWith($sformatf("Fail RF_WD got %h expected %h", RF_WD, e.value));
				assert (OUTPUT_PORT == e.value)
					else failWith($sformatf("Fail OUTPUT_PORT got %h expected %h",
						OUTPUT_PORT, e.value));
				idx++;
			end
			@(negedge CLK);
		end

		assert (idx == expTable.size()) else failWith("Halt came before all expected writes");
		assert (NUM_INST == expTable.size() + otherCount)
			else failWith($sformatf("Fail NUM_INST got %h expected %h", NUM_INST,
				expTable.size() + otherCount));
		assert (dmem[66] == expWord66)
			else failWith($sformatf("Fail dmem[66] got %h expected %h", dmem[66], expWord66));
		assert (dmem[67] == expWord67)
			else failWith($sformatf("Fail dmem[67] got %h expected %h", dmem[67], expWord67));

		// Nothing retires after the halt
		repeat (8) begin
			@(negedge CLK);
			assert (HALT == 1'b1) else failWith("HALT dropped after the halt instruction");
			assert (RF_WE == 1'b0) else failWith("Register write after the halt instruction");
		end

		$display("sim passed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+testbench
verilog/rvPkg.sv
verilog/stageReg.sv
verilog/decoder.sv
verilog/execUnit.sv
verilog/hazardUnit.sv
verilog/memAccess.sv
verilog/rvCore.sv
testbench/tbCore.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tbCore -f filelist.f -o simCore
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/simCore)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
